//--- Bender.yml
package:
  name: moller_top

sources:
  - common/moller_cfg_pkg.sv
  - common/moller_regs_pkg.sv
  - hw/apb_regmap.sv
  - hw/convert_timer.sv
  - stream/stream_decimator.sv
  - stream/stream_packer.sv
  - hw/moller_top.sv
  - target: test
    files:
      - tests/moller_top_properties.sv
      - tests/moller_top_tb.sv

//--- common/moller_cfg_pkg.sv
package moller_cfg_pkg;

    // Board defaults
    localparam int NUM_ADC_CH = 16;    // LTC2387 channels on the board
    localparam int SAMPLE_W   = 18;    // Signed ADC sample

    // Time and stream
    localparam int TS_W       = 64;    // Free-running timestamp
    localparam int WORD_W     = 64;    // Stream word, header or two samples

    // Stream control fields
    localparam int CH_SEL_W   = 4;     // Channel index
    localparam int NSAMP_W    = 16;    // Samples per packet
    localparam int RATE_DIV_W = 7;     // Keep one of rate_div+1
    localparam int RATE_W     = 8;     // Convert period in clk cycles

endpackage

//--- common/moller_regs_pkg.sv
package moller_regs_pkg;

    localparam int APB_ADDR_W = 12;
    localparam int APB_DATA_W = 32;

    localparam logic [APB_DATA_W-1:0] MOLLER_REVISION = 32'h0002_0105;

    // Register map, byte addresses
    localparam logic [APB_ADDR_W-1:0] REG_REVISION    = 12'h000;
    localparam logic [APB_ADDR_W-1:0] REG_ADC_CTRL    = 12'h004;
    localparam logic [APB_ADDR_W-1:0] REG_STREAM_CTRL = 12'h008;
    localparam logic [APB_ADDR_W-1:0] REG_STATUS      = 12'h00C;
    localparam logic [APB_ADDR_W-1:0] REG_DROP_COUNT  = 12'h010;  // Any write clears

    // ADC_CTRL fields
    localparam int ADC_TESTPAT_BIT = 0;
    localparam int ADC_PD_BIT      = 1;   // Power-down, pin is active low
    localparam int ADC_RATE_LSB    = 8;
    localparam int ADC_RATE_MSB    = 15;

    // STREAM_CTRL fields
    localparam int STR_ENA_BIT   = 31;
    localparam int STR_RDIV_LSB  = 24;
    localparam int STR_RDIV_MSB  = 30;
    localparam int STR_CH1_LSB   = 20;
    localparam int STR_CH1_MSB   = 23;
    localparam int STR_CH0_LSB   = 16;
    localparam int STR_CH0_MSB   = 19;
    localparam int STR_NSAMP_LSB = 0;
    localparam int STR_NSAMP_MSB = 15;

    // STATUS fields
    localparam int STAT_LOCK_BIT = 0;     // LMK lock detect
    localparam int STAT_HOLD_BIT = 1;     // LMK holdover

endpackage

//--- hw/apb_regmap.sv
`timescale 1ns/1ps

module apb_regmap (
    input  logic clk,
    input  logic rst_n,

    input  logic [moller_regs_pkg::APB_ADDR_W-1:0] paddr,
    input  logic                                   psel,
    input  logic                                   penable,
    input  logic                                   pwrite,
    input  logic [moller_regs_pkg::APB_DATA_W-1:0] pwdata,
    output logic [moller_regs_pkg::APB_DATA_W-1:0] prdata,
    output logic                                   pready,
    output logic                                   pslverr,

    input  logic                                   lmk_lock_detect,
    input  logic                                   lmk_holdover,
    input  logic [moller_regs_pkg::APB_DATA_W-1:0] drop_count,

    output logic                                   adc_testpat,
    output logic                                   adc_pd_n,
    output logic [moller_cfg_pkg::RATE_W-1:0]      sample_rate,

    output logic                                   stream_ena,
    output logic [moller_cfg_pkg::RATE_DIV_W-1:0]  rate_div,
    output logic [moller_cfg_pkg::CH_SEL_W-1:0]    ch0_sel,
    output logic [moller_cfg_pkg::CH_SEL_W-1:0]    ch1_sel,
    output logic [moller_cfg_pkg::NSAMP_W-1:0]     num_samples,

    output logic                                   drop_clear
);

    logic [moller_regs_pkg::APB_DATA_W-1:0] adc_ctrl_q;
    logic [moller_regs_pkg::APB_DATA_W-1:0] stream_ctrl_q;
    logic [1:0] lock_sync;                 // Two-flop synchronizers
    logic [1:0] hold_sync;
    logic       access;
    logic       wr_en;
    logic       addr_hit;

    assign pready = 1'b1;                  // Zero wait states
    assign access = psel & penable;
    assign wr_en  = access & pwrite;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            adc_ctrl_q    <= '0;           // sample_rate 0, no converts
            stream_ctrl_q <= '0;
            lock_sync     <= '0;
            hold_sync     <= '0;
        end else begin
            lock_sync <= {lock_sync[0], lmk_lock_detect};
            hold_sync <= {hold_sync[0], lmk_holdover};
            if (wr_en && paddr == moller_regs_pkg::REG_ADC_CTRL)
                adc_ctrl_q <= pwdata;
            if (wr_en && paddr == moller_regs_pkg::REG_STREAM_CTRL)
                stream_ctrl_q <= pwdata;
        end
    end

    // Read mux and decode, valid during the access phase
    always_comb begin
        prdata   = '0;
        addr_hit = 1'b1;
        case (paddr)
            moller_regs_pkg::REG_REVISION:    prdata = moller_regs_pkg::MOLLER_REVISION;
            moller_regs_pkg::REG_ADC_CTRL:    prdata = adc_ctrl_q;
            moller_regs_pkg::REG_STREAM_CTRL: prdata = stream_ctrl_q;
            moller_regs_pkg::REG_STATUS: begin
                prdata[moller_regs_pkg::STAT_LOCK_BIT] = lock_sync[1];
                prdata[moller_regs_pkg::STAT_HOLD_BIT] = hold_sync[1];
            end
            moller_regs_pkg::REG_DROP_COUNT:  prdata = drop_count;
            default:                          addr_hit = 1'b0;   // Hole in the map
        endcase
    end

    assign pslverr    = access & ~addr_hit;
    assign drop_clear = wr_en & (paddr == moller_regs_pkg::REG_DROP_COUNT);  // Data ignored

    // ADC control fields
    assign adc_testpat = adc_ctrl_q[moller_regs_pkg::ADC_TESTPAT_BIT];
    assign adc_pd_n    = ~adc_ctrl_q[moller_regs_pkg::ADC_PD_BIT];
    assign sample_rate = adc_ctrl_q[moller_regs_pkg::ADC_RATE_MSB:moller_regs_pkg::ADC_RATE_LSB];

    // Stream control fields
    assign stream_ena  = stream_ctrl_q[moller_regs_pkg::STR_ENA_BIT];
    assign rate_div    = stream_ctrl_q[moller_regs_pkg::STR_RDIV_MSB:moller_regs_pkg::STR_RDIV_LSB];
    assign ch1_sel     = stream_ctrl_q[moller_regs_pkg::STR_CH1_MSB:moller_regs_pkg::STR_CH1_LSB];
    assign ch0_sel     = stream_ctrl_q[moller_regs_pkg::STR_CH0_MSB:moller_regs_pkg::STR_CH0_LSB];
    assign num_samples =
        stream_ctrl_q[moller_regs_pkg::STR_NSAMP_MSB:moller_regs_pkg::STR_NSAMP_LSB];

endmodule

//--- hw/convert_timer.sv
`timescale 1ns/1ps

module convert_timer (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [moller_cfg_pkg::RATE_W-1:0] sample_rate,   // Period in cycles, 0 stops
    output logic                              adc_convert,
    output logic [moller_cfg_pkg::TS_W-1:0]   convert_ts
);

    logic [moller_cfg_pkg::TS_W-1:0]   ts_cnt;     // Free-running timestamp
    logic [moller_cfg_pkg::RATE_W-1:0] period_cnt; // Cycles left to next pulse

    always_ff @(posedge clk) begin
        if (!rst_n)
            ts_cnt <= '0;                  // Zero in the first cycle out of reset
        else
            ts_cnt <= ts_cnt + 1'b1;
    end

    // Pulse on terminal count, then reload
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            period_cnt  <= '0;
            adc_convert <= 1'b0;
        end else if (sample_rate == '0) begin
            period_cnt  <= '0;             // Conversions stopped
            adc_convert <= 1'b0;
        end else if (period_cnt == '0) begin
            period_cnt  <= sample_rate - 1'b1;
            adc_convert <= 1'b1;
        end else begin
            period_cnt  <= period_cnt - 1'b1;
            adc_convert <= 1'b0;
        end
    end

    // Stamp of the pulse cycle, held until the next pulse
    always_ff @(posedge clk) begin
        if (adc_convert)
            convert_ts <= ts_cnt;
    end

endmodule

//--- hw/moller_top.sv
`timescale 1ns/1ps

module moller_top #(
    parameter int NUM_CH     = moller_cfg_pkg::NUM_ADC_CH,
    parameter int FIFO_DEPTH = 8                          // Power of two
)(
    input  logic clk,
    input  logic rst_n,

    // APB slave
    input  logic [moller_regs_pkg::APB_ADDR_W-1:0] paddr,
    input  logic                                   psel,
    input  logic                                   penable,
    input  logic                                   pwrite,
    input  logic [moller_regs_pkg::APB_DATA_W-1:0] pwdata,
    output logic [moller_regs_pkg::APB_DATA_W-1:0] prdata,
    output logic                                   pready,
    output logic                                   pslverr,

    // LMK status pins, asynchronous
    input  logic lmk_lock_detect,
    input  logic lmk_holdover,

    // ADC parallel side
    input  logic                                       adc_valid,
    input  logic [NUM_CH-1:0][moller_cfg_pkg::SAMPLE_W-1:0] adc_data,
    output logic                                       adc_convert,
    output logic                                       adc_testpat,
    output logic                                       adc_pd_n,

    // Packet stream out
    output logic [moller_cfg_pkg::WORD_W-1:0] stream_data,
    output logic                              stream_last,
    output logic                              stream_valid,
    input  logic                              stream_ready
);

    // Control fields from the register block
    logic [moller_cfg_pkg::RATE_W-1:0]     sample_rate;
    logic                                  stream_ena;
    logic [moller_cfg_pkg::RATE_DIV_W-1:0] rate_div;
    logic [moller_cfg_pkg::CH_SEL_W-1:0]   ch0_sel;
    logic [moller_cfg_pkg::CH_SEL_W-1:0]   ch1_sel;
    logic [moller_cfg_pkg::NSAMP_W-1:0]    num_samples;

    logic [31:0]                     drop_count;
    logic                            drop_clear;
    logic [moller_cfg_pkg::TS_W-1:0] convert_ts;   // Stamp of the last convert

    // Decimator to packer, no back-pressure
    logic                                pick_valid;
    logic                                pick_first;
    logic                                pick_last;
    logic [moller_cfg_pkg::SAMPLE_W-1:0] pick_ch0;
    logic [moller_cfg_pkg::SAMPLE_W-1:0] pick_ch1;
    logic [moller_cfg_pkg::TS_W-1:0]     pick_ts;

    apb_regmap u_regmap (
        .clk(clk), .rst_n(rst_n),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .lmk_lock_detect(lmk_lock_detect), .lmk_holdover(lmk_holdover),
        .drop_count(drop_count),
        .adc_testpat(adc_testpat), .adc_pd_n(adc_pd_n), .sample_rate(sample_rate),
        .stream_ena(stream_ena), .rate_div(rate_div),
        .ch0_sel(ch0_sel), .ch1_sel(ch1_sel), .num_samples(num_samples),
        .drop_clear(drop_clear)
    );

    convert_timer u_timer (
        .clk(clk), .rst_n(rst_n),
        .sample_rate(sample_rate),
        .adc_convert(adc_convert),
        .convert_ts(convert_ts)
    );

    stream_decimator #(.NUM_CH(NUM_CH)) u_decim (
        .clk(clk), .rst_n(rst_n),
        .adc_valid(adc_valid), .adc_data(adc_data), .convert_ts(convert_ts),
        .stream_ena(stream_ena), .rate_div(rate_div),
        .ch0_sel(ch0_sel), .ch1_sel(ch1_sel), .num_samples(num_samples),
        .pick_valid(pick_valid), .pick_first(pick_first), .pick_last(pick_last),
        .pick_ch0(pick_ch0), .pick_ch1(pick_ch1), .pick_ts(pick_ts)
    );

    stream_packer #(.FIFO_DEPTH(FIFO_DEPTH)) u_packer (
        .clk(clk), .rst_n(rst_n),
        .pick_valid(pick_valid), .pick_first(pick_first), .pick_last(pick_last),
        .pick_ch0(pick_ch0), .pick_ch1(pick_ch1), .pick_ts(pick_ts),
        .stream_ready(stream_ready), .drop_clear(drop_clear),
        .stream_data(stream_data), .stream_last(stream_last),
        .stream_valid(stream_valid), .drop_count(drop_count)
    );

endmodule

//--- moller_top.f
common/moller_cfg_pkg.sv
common/moller_regs_pkg.sv
hw/apb_regmap.sv
hw/convert_timer.sv
stream/stream_decimator.sv
stream/stream_packer.sv
hw/moller_top.sv
tests/moller_top_properties.sv
tests/moller_top_tb.sv

//--- stream/stream_decimator.sv
`timescale 1ns/1ps

module stream_decimator #(
    parameter int NUM_CH = 16
)(
    input  logic clk,
    input  logic rst_n,

    input  logic                                            adc_valid,
    input  logic [NUM_CH-1:0][moller_cfg_pkg::SAMPLE_W-1:0] adc_data,
    input  logic [moller_cfg_pkg::TS_W-1:0]                 convert_ts,

    input  logic                                  stream_ena,
    input  logic [moller_cfg_pkg::RATE_DIV_W-1:0] rate_div,
    input  logic [moller_cfg_pkg::CH_SEL_W-1:0]   ch0_sel,
    input  logic [moller_cfg_pkg::CH_SEL_W-1:0]   ch1_sel,
    input  logic [moller_cfg_pkg::NSAMP_W-1:0]    num_samples,

    output logic                                pick_valid,
    output logic                                pick_first,
    output logic                                pick_last,
    output logic [moller_cfg_pkg::SAMPLE_W-1:0] pick_ch0,
    output logic [moller_cfg_pkg::SAMPLE_W-1:0] pick_ch1,
    output logic [moller_cfg_pkg::TS_W-1:0]     pick_ts
);

    logic [moller_cfg_pkg::RATE_DIV_W-1:0] div_cnt;   // Samples still to skip
    logic [moller_cfg_pkg::NSAMP_W-1:0]    samp_cnt;  // Position inside the packet
    logic [moller_cfg_pkg::NSAMP_W-1:0]    last_idx;
    logic                                  take;
    logic                                  is_last;

    // num_samples of 0 behaves as 1
    assign last_idx = (num_samples == '0) ? '0 : num_samples - 1'b1;
    assign is_last  = (samp_cnt == last_idx);
    assign take     = adc_valid & stream_ena & (div_cnt == '0);

    // Counters sit at zero while disabled, so a rising enable starts clean
    always_ff @(posedge clk) begin
        if (!rst_n || !stream_ena) begin
            div_cnt  <= '0;
            samp_cnt <= '0;
        end else if (adc_valid) begin
            div_cnt <= (div_cnt == '0) ? rate_div : div_cnt - 1'b1;
            if (take)
                samp_cnt <= is_last ? '0 : samp_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            pick_valid <= 1'b0;
        else
            pick_valid <= take;            // One cycle after the accepted sample
    end

    // Payload, qualified by pick_valid
    always_ff @(posedge clk) begin
        if (take) begin
            pick_first <= (samp_cnt == '0);
            pick_last  <= is_last;
            pick_ch0   <= adc_data[ch0_sel];
            pick_ch1   <= adc_data[ch1_sel];
            pick_ts    <= convert_ts;
        end
    end

endmodule

//--- stream/stream_packer.sv
`timescale 1ns/1ps

module stream_packer #(
    parameter int FIFO_DEPTH = 8           // Power of two, at least 2
)(
    input  logic clk,
    input  logic rst_n,

    input  logic                                pick_valid,
    input  logic                                pick_first,
    input  logic                                pick_last,
    input  logic [moller_cfg_pkg::SAMPLE_W-1:0] pick_ch0,
    input  logic [moller_cfg_pkg::SAMPLE_W-1:0] pick_ch1,
    input  logic [moller_cfg_pkg::TS_W-1:0]     pick_ts,

    input  logic stream_ready,
    input  logic drop_clear,

    output logic [moller_cfg_pkg::WORD_W-1:0] stream_data,
    output logic                              stream_last,
    output logic                              stream_valid,
    output logic [31:0]                       drop_count
);

    localparam int PTR_W  = $clog2(FIFO_DEPTH);
    localparam int HALF_W = moller_cfg_pkg::WORD_W / 2;
    localparam int EXT_W  = HALF_W - moller_cfg_pkg::SAMPLE_W;

    logic [moller_cfg_pkg::WORD_W:0] mem [FIFO_DEPTH];   // {last, word}
    logic [PTR_W:0]   wr_ptr;
    logic [PTR_W:0]   rd_ptr;
    logic [PTR_W:0]   count;
    logic [PTR_W-1:0] wr_idx;
    logic [PTR_W-1:0] wr_idx_nxt;
    logic [1:0]       need;
    logic             pend_hdr;            // Header owed to a moved packet start
    logic             hdr_needed;
    logic             space_ok;
    logic             drop;
    logic [moller_cfg_pkg::WORD_W-1:0] sample_word;

    // ch1 in the upper half, ch0 in the lower, both sign-extended
    assign sample_word = {{EXT_W{pick_ch1[moller_cfg_pkg::SAMPLE_W-1]}}, pick_ch1,
                          {EXT_W{pick_ch0[moller_cfg_pkg::SAMPLE_W-1]}}, pick_ch0};

    assign count      = wr_ptr - rd_ptr;
    assign wr_idx     = wr_ptr[PTR_W-1:0];
    assign wr_idx_nxt = wr_idx + 1'b1;
    assign hdr_needed = pick_first | pend_hdr;
    assign need       = hdr_needed ? 2'd2 : 2'd1;
    // All or nothing, header and sample must fit together
    assign space_ok   = ({1'b0, count} + {{PTR_W{1'b0}}, need}) <= (PTR_W+2)'(FIFO_DEPTH);
    assign drop       = pick_valid & ~space_ok;

    always_ff @(posedge clk) begin
        if (pick_valid && space_ok) begin
            if (hdr_needed) begin
                mem[wr_idx]     <= {1'b0, pick_ts};
                mem[wr_idx_nxt] <= {pick_last, sample_word};
            end else begin
                mem[wr_idx]     <= {pick_last, sample_word};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            pend_hdr   <= 1'b0;
            drop_count <= '0;
        end else begin
            if (pick_valid && space_ok)
                wr_ptr <= wr_ptr + {{(PTR_W-1){1'b0}}, need};
            if (stream_valid && stream_ready)
                rd_ptr <= rd_ptr + 1'b1;
            if (pick_valid)
                pend_hdr <= hdr_needed & ~space_ok;  // Start slides to the next pick
            if (drop_clear)
                drop_count <= '0;
            else if (drop && !(&drop_count))
                drop_count <= drop_count + 1'b1;     // Saturates
        end
    end

    // Head of the FIFO, stays put until taken
    assign stream_valid              = (count != '0);
    assign {stream_last, stream_data} = mem[rd_ptr[PTR_W-1:0]];

endmodule

//--- tests/moller_top_properties.sv
`timescale 1ns/1ps

module moller_top_properties (
    input logic        clk,
    input logic        rst_n,
    input logic        stream_valid,
    input logic        stream_ready,
    input logic [63:0] stream_data,
    input logic        stream_last,
    input logic        pready
);

    // A stalled word holds until the sink takes it
    property word_held;
        @(posedge clk) disable iff (!rst_n)
            stream_valid && !stream_ready |=>
                stream_valid && $stable(stream_data) && $stable(stream_last);
    endproperty

    assert property (word_held)
        else $error("stream word changed while stalled");

    assert property (@(posedge clk) !rst_n |=> !stream_valid)
        else $error("stream_valid high in reset");

    assert property (@(posedge clk) disable iff (!rst_n) pready)  // Zero wait states
        else $error("pready low");

endmodule

bind stream_packer moller_top_properties u_stream_props (
    .clk(clk), .rst_n(rst_n), .stream_valid(stream_valid), .stream_ready(stream_ready),
    .stream_data(stream_data), .stream_last(stream_last), .pready(1'b1)
);

// Stream side tied idle here
bind apb_regmap moller_top_properties u_apb_props (
    .clk(clk), .rst_n(rst_n), .stream_valid(1'b0), .stream_ready(1'b1),
    .stream_data(64'h0), .stream_last(1'b0), .pready(pready)
);

//--- tests/moller_top_tb.sv
`timescale 1ns/1ps

module moller_top_tb;

    localparam int NUM_CH = 16;
    localparam int MAX_TESTS = 32;

    logic clk = 1'b0;
    logic rst_n;
    logic [moller_regs_pkg::APB_ADDR_W-1:0] paddr;
    logic psel;
    logic penable;
    logic pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    logic lmk_lock_detect;
    logic lmk_holdover;
    logic adc_valid;
    logic [NUM_CH-1:0][17:0] adc_data;
    logic adc_convert;
    logic adc_testpat;
    logic adc_pd_n;
    logic [63:0] stream_data;
    logic stream_last;
    logic stream_valid;
    logic stream_ready;

    // Test table from the data file
    string t_kind [MAX_TESTS];
    int t_rate [MAX_TESTS];
    int t_rdiv [MAX_TESTS];
    int t_ch0 [MAX_TESTS];
    int t_ch1 [MAX_TESTS];
    int t_nsamp [MAX_TESTS];
    int t_pkts [MAX_TESTS];
    int t_pct [MAX_TESTS];
    int ntests;

    logic [63:0] cyc;                          // Cycles since reset, same origin as the timestamp
    int errors = 0;
    longint limit_cycles = 0;
    logic [63:0] conv_log [$];                 // Cycle of every adc_convert high
    logic [63:0] due_q [$];                    // When the ADC answers
    logic [63:0] due_ts [$];                   // Convert cycle of that answer
    logic [63:0] sample_ts;
    int budget = 0;                            // Converts still to answer
    logic [31:0] adc_rng = 32'd5;
    logic [31:0] rdy_rng = 32'd5;
    bit stream_on = 1'b0;
    int samp_idx;
    int cur_rdiv;
    int cur_ch0;
    int cur_ch1;
    logic [17:0] ex_c0 [$];                    // Predicted picks
    logic [17:0] ex_c1 [$];
    logic [63:0] ex_ts [$];
    logic [64:0] rx_q [$];                     // {last, data} as received
    int ready_pct = 100;
    int low_hold = 0;

    moller_top #(.NUM_CH(NUM_CH), .FIFO_DEPTH(8)) DUT (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        if (!rst_n)
            cyc <= '0;
        else
            cyc <= cyc + 1'b1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Sample word of pick j, last on the final pick of a packet
    function automatic logic [64:0] sample_of(input int j, input int n);
        return {(j % n == n - 1), {14{ex_c1[j][17]}}, ex_c1[j], {14{ex_c0[j][17]}}, ex_c0[j]};
    endfunction

    task automatic check(input string name, input logic [64:0] got, input logic [64:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // ADC model, answers 3 cycles after each convert and records the picks it expects
    always @(negedge clk) begin
        adc_valid = 1'b0;
        if (due_q.size() != 0 && due_q[0] == cyc) begin
            void'(due_q.pop_front());
            sample_ts = due_ts.pop_front();
            adc_valid = 1'b1;
            for (int c = 0; c < NUM_CH; c++) begin
                adc_rng = xorshift(adc_rng);
                adc_data[c] = adc_rng[17:0];   // Random sign too
            end
            if (stream_on && samp_idx % (cur_rdiv + 1) == 0) begin
                ex_c0.push_back(adc_data[cur_ch0]);
                ex_c1.push_back(adc_data[cur_ch1]);
                ex_ts.push_back(sample_ts);
            end
            samp_idx++;
        end
        if (adc_convert) begin
            conv_log.push_back(cyc);
            if (budget > 0) begin
                due_q.push_back(cyc + 3);
                due_ts.push_back(cyc);
                budget--;
            end
        end
    end

    // Stream sink, ready from a random pattern with rare long stalls
    always @(negedge clk) begin
        rdy_rng = xorshift(rdy_rng);
        if (low_hold > 0)
            low_hold--;
        else if (ready_pct < 100 && rdy_rng[31:26] == '0)
            low_hold = 40;
        stream_ready = (low_hold == 0) && (rdy_rng[15:0] % 100 < ready_pct);
        if (stream_valid && stream_ready)
            rx_q.push_back({stream_last, stream_data});   // Transfers at the next rising edge
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic apb(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                       output logic [31:0] rdata, output logic err);
        @(negedge clk);
        paddr = addr;
        pwrite = wr;
        pwdata = wdata;
        psel = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;                        // Access phase, no wait states
        #10;
        rdata = prdata;
        err = pslverr;
        check("pready", pready, 1'b1);
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic reg_write(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic err;
        apb(1'b1, addr, data, rd, err);
        check("pslverr", err, 0);
    endtask

    task automatic reg_expect(input string name, input logic [11:0] addr, input logic [31:0] exp);
        logic [31:0] rd;
        logic err;
        apb(1'b0, addr, 32'h0, rd, err);
        check("pslverr", err, 0);
        check(name, rd, exp);
    endtask

    task automatic run_regs(input int i);
        logic [31:0] sc;
        sc = {1'b0, 7'(t_rdiv[i]), 4'(t_ch1[i]), 4'(t_ch0[i]), 16'(t_nsamp[i])};  // Enable off
        reg_expect("REG_REVISION", moller_regs_pkg::REG_REVISION, 32'h0002_0105);
        reg_write(moller_regs_pkg::REG_ADC_CTRL, 32'h5A00_0003);   // Testpat and power-down
        reg_write(moller_regs_pkg::REG_STREAM_CTRL, sc);
        reg_expect("REG_ADC_CTRL", moller_regs_pkg::REG_ADC_CTRL, 32'h5A00_0003);
        reg_expect("REG_STREAM_CTRL", moller_regs_pkg::REG_STREAM_CTRL, sc);
        check("adc_testpat", adc_testpat, 1);
        check("adc_pd_n", adc_pd_n, 0);
        lmk_lock_detect = 1'b1;
        wait_cycles(3);                        // Through the synchronizer
        reg_expect("REG_STATUS", moller_regs_pkg::REG_STATUS, 32'h1);
        lmk_lock_detect = 1'b0;
        lmk_holdover = 1'b1;
        wait_cycles(3);
        reg_expect("REG_STATUS", moller_regs_pkg::REG_STATUS, 32'h2);
        lmk_holdover = 1'b0;
        reg_write(moller_regs_pkg::REG_ADC_CTRL, 32'h0);
        reg_write(moller_regs_pkg::REG_STREAM_CTRL, 32'h0);
    endtask

    task automatic run_badaddr();
        logic [31:0] rd;
        logic err;
        reg_write(moller_regs_pkg::REG_ADC_CTRL, 32'h0000_0001);
        reg_write(moller_regs_pkg::REG_STREAM_CTRL, 32'h0123_4567);
        apb(1'b1, 12'h014, 32'hFFFF_FFFF, rd, err);
        check("pslverr", err, 1);
        apb(1'b1, 12'h006, 32'hFFFF_FFFF, rd, err);   // Between two registers
        check("pslverr", err, 1);
        apb(1'b0, 12'hFFC, 32'h0, rd, err);
        check("pslverr", err, 1);
        reg_expect("REG_ADC_CTRL", moller_regs_pkg::REG_ADC_CTRL, 32'h0000_0001);
        reg_expect("REG_STREAM_CTRL", moller_regs_pkg::REG_STREAM_CTRL, 32'h0123_4567);
        reg_write(moller_regs_pkg::REG_ADC_CTRL, 32'h0);
        reg_write(moller_regs_pkg::REG_STREAM_CTRL, 32'h0);
    endtask

    task automatic run_rate(input int i);
        conv_log.delete();
        reg_write(moller_regs_pkg::REG_ADC_CTRL, t_rate[i] << 8);
        while (conv_log.size() < 6)
            @(negedge clk);
        reg_write(moller_regs_pkg::REG_ADC_CTRL, 32'h0);
        for (int k = 1; k < 6; k++)
            check("adc_convert period", conv_log[k] - conv_log[k-1], t_rate[i]);  // Also width
        wait_cycles(4);
        conv_log.delete();
        wait_cycles(50);
        check("adc_convert pulses at rate 0", conv_log.size(), 0);
    endtask

    task automatic run_stream(input int i, input bit strict);
        int n;
        int j;
        int dropped;
        bit pend;
        bit want_sample;
        bit found;
        bit hdr_need;
        logic [64:0] exp_w;
        n = (t_nsamp[i] == 0) ? 1 : t_nsamp[i];
        ex_c0.delete();
        ex_c1.delete();
        ex_ts.delete();
        rx_q.delete();
        cur_rdiv = t_rdiv[i];
        cur_ch0 = t_ch0[i];
        cur_ch1 = t_ch1[i];
        samp_idx = 0;
        stream_on = 1'b1;
        ready_pct = t_pct[i];
        // Enable first, then start converts, so decimation begins at sample 0
        reg_write(moller_regs_pkg::REG_STREAM_CTRL,
                  {1'b1, 7'(t_rdiv[i]), 4'(t_ch1[i]), 4'(t_ch0[i]), 16'(t_nsamp[i])});
        budget = t_pkts[i] * n * (t_rdiv[i] + 1);
        reg_write(moller_regs_pkg::REG_ADC_CTRL, t_rate[i] << 8);
        while (budget > 0 || due_q.size() != 0)
            @(negedge clk);
        reg_write(moller_regs_pkg::REG_ADC_CTRL, 32'h0);
        wait_cycles(3);
        while (stream_valid)                   // Drain the FIFO
            @(negedge clk);
        ready_pct = 100;
        low_hold = 0;                          // No stall carried into the next test
        reg_write(moller_regs_pkg::REG_STREAM_CTRL, 32'h0);
        stream_on = 1'b0;

        // Walk received words against picks, a skipped pick counts as dropped
        j = 0;
        dropped = 0;
        pend = 1'b0;
        want_sample = 1'b0;
        foreach (rx_q[k]) begin
            if (want_sample) begin
                check("stream sample word", rx_q[k], sample_of(j, n));
                j++;
                want_sample = 1'b0;
            end else begin
                found = 1'b0;
                while (!found && j < ex_ts.size()) begin
                    hdr_need = (j % n == 0) || pend;   // Header owed after a dropped start
                    exp_w = hdr_need ? {1'b0, ex_ts[j]} : sample_of(j, n);
                    if (strict || rx_q[k] === exp_w) begin
                        check(hdr_need ? "stream header" : "stream sample word", rx_q[k], exp_w);
                        found = 1'b1;
                        pend = 1'b0;
                        want_sample = hdr_need;
                        if (!hdr_need)
                            j++;
                    end else begin
                        dropped++;
                        pend = hdr_need;
                        j++;
                    end
                end
                if (!found) begin
                    $display("stream word %h does not match any remaining pick", rx_q[k]);
                    errors++;
                end
            end
        end
        if (want_sample) begin
            $display("stream ended on a header without its sample word");
            errors++;
        end
        dropped += ex_ts.size() - j;           // Tail never arrived
        reg_expect("REG_DROP_COUNT", moller_regs_pkg::REG_DROP_COUNT, dropped);
        reg_write(moller_regs_pkg::REG_DROP_COUNT, 32'h1);
        reg_expect("REG_DROP_COUNT after clear", moller_regs_pkg::REG_DROP_COUNT, 32'h0);
    endtask

    // Watchdog, armed once the test table is known
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, a test did not finish", limit_cycles);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int fd;
        int e0;
        int nfail;
        string line;
        longint limit;
        rst_n = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        lmk_lock_detect = 1'b0;
        lmk_holdover = 1'b0;
        adc_valid = 1'b0;
        adc_data = '0;
        stream_ready = 1'b1;
        ntests = 0;
        nfail = 0;
        limit = 100;                           // Reset and start-up
        fd = $fopen("tests/moller_top_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/moller_top_tests.txt");
            $display("Simulation failed");
            $finish;
        end
        while (!$feof(fd) && ntests < MAX_TESTS) begin
            line = "";
            if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
                if ($sscanf(line, "%s %d %d %d %d %d %d %d", t_kind[ntests], t_rate[ntests],
                            t_rdiv[ntests], t_ch0[ntests], t_ch1[ntests], t_nsamp[ntests],
                            t_pkts[ntests], t_pct[ntests]) == 8) begin
                    limit += longint'(t_pkts[ntests]) * (t_nsamp[ntests] + 1)
                             * (t_rdiv[ntests] + 1) * t_rate[ntests] * 4 + 2000;
                    ntests++;
                end
            end
        end
        $fclose(fd);
        limit_cycles = limit;

        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < ntests; i++) begin
            e0 = errors;
            case (t_kind[i])
                "reg":     run_regs(i);
                "badaddr": run_badaddr();
                "rate":    run_rate(i);
                "pkt":     run_stream(i, 1'b1);      // Ready held high, no drops allowed
                "bp":      run_stream(i, 1'b0);
                default: begin
                    $display("unknown test kind %s in the test file", t_kind[i]);
                    errors++;
                end
            endcase
            if (errors != e0)
                nfail++;
            $display("test %0d %s: %s", i, t_kind[i], (errors == e0) ? "ok" : "FAILED");
        end
        $display("tests run %0d, failed %0d, check errors %0d", ntests, nfail, errors);
        if (errors == 0 && ntests > 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- tests/moller_top_tests.txt
# kind sample_rate rate_div ch0 ch1 num_samples packets ready_pct
# kinds: reg, badaddr, rate, pkt (ready high), bp (back-pressure)
reg 0 3 2 5 12 0 100
badaddr 0 0 0 0 0 0 100
rate 5 0 0 0 0 0 100
rate 13 0 0 0 0 0 100
rate 2 0 0 0 0 0 100
pkt 8 0 0 1 4 3 100
pkt 6 2 3 15 8 2 100
pkt 5 0 7 7 0 4 100
pkt 10 1 12 2 1 3 100
bp 4 0 1 2 6 8 30
bp 4 0 5 9 3 10 10
bp 5 1 0 15 4 6 50
bp 4 0 14 3 16 4 20
pkt 4 0 6 11 5 2 100
